// ==== verilog/grid_defines.svh ====
`ifndef GRID_DEFINES_SVH
`define GRID_DEFINES_SVH

// ========================================
// Datapath sizing
// ========================================

// Operand and memory word width
`define GRID_XLEN 32

// Entries per operand FIFO
`define GRID_FIFO_DEPTH 8

// ========================================
// Memory side sizing
// ========================================

`define GRID_LSQ_DEPTH 4    // Requests held by the load/store queue
`define GRID_MEM_WORDS 64   // Scratch memory words

`endif

// ==== verilog/lsq_types_pkg.sv ====
`default_nettype none

`include "grid_defines.svh"

package lsq_types_pkg;

    // Width code, same encoding as RISC-V funct3 for loads and stores
    typedef enum logic [2:0] {
        W_B  = 3'b000,  // Byte, sign extended
        W_H  = 3'b001,  // Halfword, sign extended
        W_W  = 3'b010,
        W_BU = 3'b100,  // Byte, zero extended
        W_HU = 3'b101   // Halfword, zero extended
    } mem_width_e;

    // One queued memory request
    typedef struct packed {
        logic [`GRID_XLEN-1:0] addr;
        logic [`GRID_XLEN-1:0] data;   // Store data, unused on loads
        mem_width_e            width;
        logic                  load;
        logic                  store;
    } lsq_req_t;

    // Load result at retirement
    typedef struct packed {
        logic [`GRID_XLEN-1:0] data;
        logic                  complete;
    } lsq_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/grid_types_pkg.sv ====
`default_nettype none

`include "grid_defines.svh"

package grid_types_pkg;

    // Function of the operation unit
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_XOR   = 3'd3,
        OP_LOAD  = 3'd4,
        OP_STORE = 3'd5
    } slot_op_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } unit_state_e;

    // Slot configuration, loaded by the config strobe
    typedef struct packed {
        slot_op_e                  op;
        lsq_types_pkg::mem_width_e width;  // Only used by loads and stores
    } slot_cfg_t;

    // Operand word with its valid bit
    typedef struct packed {
        logic                  valid;
        logic [`GRID_XLEN-1:0] data;
    } operand_t;

endpackage

`default_nettype wire

// ==== verilog/operand_fifo.sv ====
`default_nettype none

`include "grid_defines.svh"

module operand_fifo #(
    parameter int DEPTH = `GRID_FIFO_DEPTH
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     push,
    input  logic [`GRID_XLEN-1:0]    data_in,
    input  logic                     pop,
    output grid_types_pkg::operand_t head,
    output logic                     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`GRID_XLEN-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W-1:0]      wr_ptr;
    logic [CNT_W-1:0]      count;
    logic                  empty;
    logic                  do_push;
    logic                  do_pop;

    // Wrap at DEPTH so non power of two depths work
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign do_push = push && !full;   // Overrun drops the word
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Head is visible the cycle after the push
    assign head.valid = !empty;
    assign head.data  = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== verilog/slot_op_unit.sv ====
`default_nettype none

`include "grid_defines.svh"

module slot_op_unit (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cfg_valid,
    input  grid_types_pkg::slot_cfg_t cfg,
    input  grid_types_pkg::operand_t  op1,
    input  grid_types_pkg::operand_t  op2,
    output logic                      ack1,
    output logic                      ack2,
    output logic                      uses1,
    output logic                      uses2,
    output lsq_types_pkg::lsq_req_t   req,
    output logic                      new_request,
    input  logic                      lsq_full,
    input  lsq_types_pkg::lsq_rsp_t   rsp,
    output logic [`GRID_XLEN-1:0]     data_out,
    output logic                      data_valid_out,
    output logic                      idle
);

    localparam int PEND_W = $clog2(`GRID_LSQ_DEPTH + 1);

    grid_types_pkg::slot_cfg_t   cfg_q;
    grid_types_pkg::unit_state_e state_q;
    grid_types_pkg::unit_state_e state_d;
    logic [PEND_W-1:0]           pend_cnt;   // Loads issued but not yet returned
    logic                        is_alu;
    logic                        is_load;
    logic                        is_store;
    logic                        issue_alu;
    logic                        issue_load;
    logic                        issue_store;
    logic                        issue_any;
    logic                        heads_empty;
    logic                        cfg_accept;
    logic [`GRID_XLEN-1:0]       alu_result;

    // ========================================
    // Decode of the latched function
    // ========================================

    assign is_alu   = cfg_q.op inside {grid_types_pkg::OP_ADD, grid_types_pkg::OP_SUB,
                                       grid_types_pkg::OP_AND, grid_types_pkg::OP_XOR};
    assign is_load  = (cfg_q.op == grid_types_pkg::OP_LOAD);
    assign is_store = (cfg_q.op == grid_types_pkg::OP_STORE);

    assign uses1 = is_alu || is_load || is_store;
    assign uses2 = is_alu || is_store;   // Loads take only the address stream

    always_comb begin
        case (cfg_q.op)
            grid_types_pkg::OP_ADD: alu_result = op1.data + op2.data;
            grid_types_pkg::OP_SUB: alu_result = op1.data - op2.data;
            grid_types_pkg::OP_AND: alu_result = op1.data & op2.data;
            grid_types_pkg::OP_XOR: alu_result = op1.data ^ op2.data;
            default:                alu_result = '0;
        endcase
    end

    // Issue conditions, acks pop the FIFO heads at the next edge
    assign issue_alu   = is_alu && op1.valid && op2.valid;
    assign issue_store = is_store && op1.valid && op2.valid && !lsq_full;
    assign issue_load  = is_load && op1.valid && !lsq_full;
    assign issue_any   = issue_alu || issue_store || issue_load;

    assign ack1        = issue_any;
    assign ack2        = issue_alu || issue_store;
    assign new_request = issue_load || issue_store;

    always_comb begin
        req.addr  = op1.data;
        req.data  = op2.data;
        req.width = cfg_q.width;
        req.load  = is_load;
        req.store = is_store;
    end

    // ========================================
    // Configuration and state
    // ========================================

    assign heads_empty = !op1.valid && !op2.valid;
    assign cfg_accept  = cfg_valid && (state_q == grid_types_pkg::ST_IDLE) && heads_empty;

    always_comb begin
        state_d = state_q;
        case (state_q)
            grid_types_pkg::ST_IDLE: begin
                if (issue_any) begin
                    state_d = grid_types_pkg::ST_RUN;
                end
            end
            grid_types_pkg::ST_RUN: begin
                if (!issue_any && heads_empty && pend_cnt == '0) begin
                    state_d = grid_types_pkg::ST_IDLE;
                end
            end
            default: state_d = grid_types_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_q          <= '{op: grid_types_pkg::OP_ADD, width: lsq_types_pkg::W_W};
            state_q        <= grid_types_pkg::ST_IDLE;
            pend_cnt       <= '0;
            data_valid_out <= 1'b0;
        end else begin
            if (cfg_accept) begin
                cfg_q <= cfg;   // Queued data is kept
            end
            state_q        <= state_d;
            pend_cnt       <= pend_cnt + PEND_W'(issue_load) - PEND_W'(rsp.complete);
            data_valid_out <= issue_alu || rsp.complete;
        end
    end

    // ALU and load returns never overlap, config only changes with no load in flight
    always_ff @(posedge clk) begin
        if (issue_alu) begin
            data_out <= alu_result;
        end else if (rsp.complete) begin
            data_out <= rsp.data;
        end
    end

    assign idle = (state_q == grid_types_pkg::ST_IDLE);

endmodule

`default_nettype wire

// ==== verilog/grid_pr_slot.sv ====
`default_nettype none

`include "grid_defines.svh"

module grid_pr_slot (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cfg_valid,
    input  grid_types_pkg::slot_cfg_t cfg,
    input  grid_types_pkg::operand_t  in1,
    input  grid_types_pkg::operand_t  in2,
    output logic [`GRID_XLEN-1:0]     data_out,
    output logic                      data_valid_out,
    output logic                      idle,
    output lsq_types_pkg::lsq_req_t   req,
    output logic                      new_request,
    input  logic                      lsq_full,
    input  lsq_types_pkg::lsq_rsp_t   rsp
);

    // Operands arrive at different rates, so each stream gets a FIFO
    grid_types_pkg::operand_t head1;
    grid_types_pkg::operand_t head2;
    logic                     ack1;
    logic                     ack2;
    logic                     uses1;
    logic                     uses2;
    logic                     full1;
    logic                     full2;
    logic                     push1;
    logic                     push2;
    logic                     unit_idle;

    // Unused operands are dropped at the FIFO input
    assign push1 = in1.valid && uses1 && !full1;
    assign push2 = in2.valid && uses2 && !full2;

    operand_fifo #(.DEPTH(`GRID_FIFO_DEPTH)) in1_fifo (
        .clk     (clk),
        .arst_n  (arst_n),
        .push    (push1),
        .data_in (in1.data),
        .pop     (ack1),
        .head    (head1),
        .full    (full1)
    );

    operand_fifo #(.DEPTH(`GRID_FIFO_DEPTH)) in2_fifo (
        .clk     (clk),
        .arst_n  (arst_n),
        .push    (push2),
        .data_in (in2.data),
        .pop     (ack2),
        .head    (head2),
        .full    (full2)
    );

    slot_op_unit op_unit (
        .clk            (clk),
        .arst_n         (arst_n),
        .cfg_valid      (cfg_valid),
        .cfg            (cfg),
        .op1            (head1),
        .op2            (head2),
        .ack1           (ack1),
        .ack2           (ack2),
        .uses1          (uses1),
        .uses2          (uses2),
        .req            (req),
        .new_request    (new_request),
        .lsq_full       (lsq_full),
        .rsp            (rsp),
        .data_out       (data_out),
        .data_valid_out (data_valid_out),
        .idle           (unit_idle)
    );

    assign idle = unit_idle && !head1.valid && !head2.valid;   // Nothing queued either

endmodule

`default_nettype wire

// ==== verilog/slot_lsq.sv ====
`default_nettype none

`include "grid_defines.svh"

module slot_lsq (
    input  logic                    clk,
    input  logic                    arst_n,
    input  lsq_types_pkg::lsq_req_t req,
    input  logic                    new_request,
    output logic                    lsq_full,
    output lsq_types_pkg::lsq_rsp_t rsp
);

    localparam int DEPTH  = `GRID_LSQ_DEPTH;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int IDX_W  = $clog2(`GRID_MEM_WORDS);
    localparam int NBYTES = `GRID_XLEN / 8;

    lsq_types_pkg::lsq_req_t queue [DEPTH];
    lsq_types_pkg::lsq_req_t head;
    logic [`GRID_XLEN-1:0]   mem [`GRID_MEM_WORDS];
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W-1:0]        wr_ptr;
    logic [CNT_W-1:0]        count;
    logic                    accept;
    logic                    retire;
    logic [IDX_W-1:0]        head_idx;
    logic [1:0]              lane;       // Byte lane of the access
    logic [NBYTES-1:0]       byte_en;
    logic [`GRID_XLEN-1:0]   wr_shift;
    logic [`GRID_XLEN-1:0]   rd_shift;

    // ========================================
    // In-order request queue
    // ========================================

    assign lsq_full = (count == CNT_W'(DEPTH));
    assign accept   = new_request && !lsq_full;
    assign retire   = (count != '0);   // Head leaves one cycle after it was taken
    assign head     = queue[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(accept) - CNT_W'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            queue[wr_ptr] <= req;
        end
    end

    // ========================================
    // Scratch memory access at retirement
    // ========================================

    assign head_idx = head.addr[IDX_W+1:2];

    always_comb begin
        case (head.width)
            lsq_types_pkg::W_B, lsq_types_pkg::W_BU: begin
                lane    = head.addr[1:0];
                byte_en = NBYTES'(4'b0001) << lane;
            end
            lsq_types_pkg::W_H, lsq_types_pkg::W_HU: begin
                lane    = {head.addr[1], 1'b0};   // Halfword aligned
                byte_en = NBYTES'(4'b0011) << lane;
            end
            default: begin
                lane    = 2'b00;
                byte_en = '1;
            end
        endcase
        wr_shift = head.data << {lane, 3'b000};
        rd_shift = mem[head_idx] >> {lane, 3'b000};
    end

    // Byte merge on stores
    always_ff @(posedge clk) begin
        if (retire && head.store) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (byte_en[b]) begin
                    mem[head_idx][b*8 +: 8] <= wr_shift[b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        case (head.width)
            lsq_types_pkg::W_B:  rsp.data = {{(`GRID_XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
            lsq_types_pkg::W_BU: rsp.data = {{(`GRID_XLEN-8){1'b0}}, rd_shift[7:0]};
            lsq_types_pkg::W_H:  rsp.data = {{(`GRID_XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
            lsq_types_pkg::W_HU: rsp.data = {{(`GRID_XLEN-16){1'b0}}, rd_shift[15:0]};
            default:             rsp.data = rd_shift;
        endcase
        rsp.complete = retire && head.load;   // One cycle pulse per load
    end

endmodule

`default_nettype wire

// ==== verilog/grid_slot_top.sv ====
`default_nettype none

`include "grid_defines.svh"

module grid_slot_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cfg_valid,
    input  grid_types_pkg::slot_cfg_t cfg,
    input  grid_types_pkg::operand_t  in1,
    input  grid_types_pkg::operand_t  in2,
    output logic [`GRID_XLEN-1:0]     data_out,
    output logic                      data_valid_out,
    output logic                      idle
);

    // Slot to load/store queue link
    lsq_types_pkg::lsq_req_t req;
    lsq_types_pkg::lsq_rsp_t rsp;
    logic                    new_request;
    logic                    lsq_full;

    grid_pr_slot slot (
        .clk            (clk),
        .arst_n         (arst_n),
        .cfg_valid      (cfg_valid),
        .cfg            (cfg),
        .in1            (in1),
        .in2            (in2),
        .data_out       (data_out),
        .data_valid_out (data_valid_out),
        .idle           (idle),
        .req            (req),
        .new_request    (new_request),
        .lsq_full       (lsq_full),
        .rsp            (rsp)
    );

    slot_lsq lsq (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .new_request (new_request),
        .lsq_full    (lsq_full),
        .rsp         (rsp)
    );

endmodule

`default_nettype wire

// ==== verif/tb_grid_slot.sv ====
`default_nettype none

`include "grid_defines.svh"

module tb_grid_slot;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          BURST_LEN      = `GRID_LSQ_DEPTH + 2;   // Deeper than the LSQ
    localparam int          IDX_W          = $clog2(`GRID_MEM_WORDS);
    localparam logic [31:0] BURST_BASE     = 32'h40;

    // One row of the stimulus table
    typedef struct {
        grid_types_pkg::slot_op_e  op;
        lsq_types_pkg::mem_width_e width;
        logic [31:0]               a;          // Operand 1 or the memory address
        logic [31:0]               b;
        int                        d2;         // Cycles operand 2 lags (negative for the reverse)
        logic [31:0]               exp_data;
        bit                        has_result;
    } entry_t;

    logic                      clk;
    logic                      arst_n;
    logic                      cfg_valid;
    grid_types_pkg::slot_cfg_t cfg;
    grid_types_pkg::operand_t  in1;
    grid_types_pkg::operand_t  in2;
    logic [`GRID_XLEN-1:0]     data_out;
    logic                      data_valid_out;
    logic                      idle;

    entry_t      stim_table [$];
    logic [31:0] results [$];
    logic [31:0] shadow_mem [`GRID_MEM_WORDS];   // Reference copy of the scratch memory
    int          loads_in_flight = 0;            // Burst loads whose result is still due
    bit          idle_early      = 1'b0;

    grid_slot_top u_dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .cfg_valid      (cfg_valid),
        .cfg            (cfg),
        .in1            (in1),
        .in2            (in2),
        .data_out       (data_out),
        .data_valid_out (data_valid_out),
        .idle           (idle)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            if (idle && loads_in_flight > 0) begin
                idle_early = 1'b1;
            end
            if (data_valid_out) begin
                results.push_back(data_out);
                if (loads_in_flight > 0) begin
                    loads_in_flight--;
                end
            end
        end
    end

    // ========================================
    // Reference model
    // ========================================

    function automatic logic [31:0] alu_model(input grid_types_pkg::slot_op_e op,
                                              input logic [31:0] a, input logic [31:0] b);
        case (op)
            grid_types_pkg::OP_ADD: return a + b;
            grid_types_pkg::OP_SUB: return a - b;
            grid_types_pkg::OP_AND: return a & b;
            default:                return a ^ b;
        endcase
    endfunction

    task automatic store_model(input lsq_types_pkg::mem_width_e width,
                               input logic [31:0] addr, input logic [31:0] data);
        case (width)
            lsq_types_pkg::W_B: shadow_mem[addr[IDX_W+1:2]][8*addr[1:0] +: 8] = data[7:0];
            lsq_types_pkg::W_H: shadow_mem[addr[IDX_W+1:2]][16*addr[1] +: 16] = data[15:0];
            default:            shadow_mem[addr[IDX_W+1:2]] = data;
        endcase
    endtask

    function automatic logic [31:0] load_model(input lsq_types_pkg::mem_width_e width,
                                               input logic [31:0] addr);
        logic [31:0] word;
        logic [7:0]  b8;
        logic [15:0] h16;
        word = shadow_mem[addr[IDX_W+1:2]];
        b8   = word[8*addr[1:0] +: 8];
        h16  = word[16*addr[1] +: 16];   // Halfword lane ignores address bit 0
        case (width)
            lsq_types_pkg::W_B:  return {{24{b8[7]}}, b8};
            lsq_types_pkg::W_BU: return {24'h0, b8};
            lsq_types_pkg::W_H:  return {{16{h16[15]}}, h16};
            lsq_types_pkg::W_HU: return {16'h0, h16};
            default:             return word;
        endcase
    endfunction

    task automatic add_entry(input grid_types_pkg::slot_op_e op,
                             input lsq_types_pkg::mem_width_e width,
                             input logic [31:0] a, input logic [31:0] b, input int d2);
        entry_t e;
        e.op         = op;
        e.width      = width;
        e.a          = a;
        e.b          = b;
        e.d2         = d2;
        e.has_result = (op != grid_types_pkg::OP_STORE);
        e.exp_data   = '0;
        case (op)
            grid_types_pkg::OP_STORE: store_model(width, a, b);
            grid_types_pkg::OP_LOAD:  e.exp_data = load_model(width, a);
            default:                  e.exp_data = alu_model(op, a, b);
        endcase
        stim_table.push_back(e);
    endtask

    task automatic build_table();
        // ALU with operand 2 on time, late and early
        add_entry(grid_types_pkg::OP_ADD, lsq_types_pkg::W_W, $urandom(), $urandom(), 0);
        add_entry(grid_types_pkg::OP_SUB, lsq_types_pkg::W_W, $urandom(), $urandom(), 3);
        add_entry(grid_types_pkg::OP_AND, lsq_types_pkg::W_W, $urandom(), $urandom(), -2);
        add_entry(grid_types_pkg::OP_XOR, lsq_types_pkg::W_W, $urandom(), $urandom(), 1);
        add_entry(grid_types_pkg::OP_ADD, lsq_types_pkg::W_W, $urandom(), $urandom(), -4);
        // Word round trip and an ALU op that must not see the load's operand 2
        add_entry(grid_types_pkg::OP_STORE, lsq_types_pkg::W_W, 32'h10, $urandom(), 0);
        add_entry(grid_types_pkg::OP_LOAD, lsq_types_pkg::W_W, 32'h10, $urandom(), 0);
        add_entry(grid_types_pkg::OP_SUB, lsq_types_pkg::W_W, $urandom(), $urandom(), 1);
        // Sub-word merges with the sign bits set
        add_entry(grid_types_pkg::OP_STORE, lsq_types_pkg::W_W, 32'h20, $urandom(), 0);
        add_entry(grid_types_pkg::OP_STORE, lsq_types_pkg::W_B, 32'h21, $urandom() | 32'h80, 0);
        add_entry(grid_types_pkg::OP_STORE, lsq_types_pkg::W_H, 32'h22,
                  $urandom() | 32'h8000, -1);
        add_entry(grid_types_pkg::OP_LOAD, lsq_types_pkg::W_W, 32'h20, $urandom(), 0);
        add_entry(grid_types_pkg::OP_LOAD, lsq_types_pkg::W_B, 32'h21, $urandom(), 0);
        add_entry(grid_types_pkg::OP_LOAD, lsq_types_pkg::W_BU, 32'h21, $urandom(), 0);
        add_entry(grid_types_pkg::OP_LOAD, lsq_types_pkg::W_H, 32'h22, $urandom(), 0);
        add_entry(grid_types_pkg::OP_LOAD, lsq_types_pkg::W_HU, 32'h22, $urandom(), 0);
        add_entry(grid_types_pkg::OP_LOAD, lsq_types_pkg::W_HU, 32'h20, $urandom(), 0);
        add_entry(grid_types_pkg::OP_LOAD, lsq_types_pkg::W_B, 32'h23, $urandom(), 0);
        // Words for the load burst
        for (int i = 0; i < BURST_LEN; i++) begin
            add_entry(grid_types_pkg::OP_STORE, lsq_types_pkg::W_W,
                      BURST_BASE + 32'(4 * i), $urandom(), 0);
        end
    endtask

    // ========================================
    // Checks and waits
    // ========================================

    task automatic stop_with_error(input string what);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", what);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_with_error($sformatf("%s does not match", name));
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!idle) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                stop_with_error("slot never returned to idle");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_results(input int n);
        int cycles;
        cycles = 0;
        while (results.size() < n) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                stop_with_error($sformatf("timed out waiting for %0d results", n));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================

    task automatic configure(input grid_types_pkg::slot_op_e op,
                             input lsq_types_pkg::mem_width_e width);
        wait_idle();
        @(posedge clk);
        #1;
        cfg_valid = 1'b1;
        cfg.op    = op;
        cfg.width = width;
        @(posedge clk);
        #1;
        cfg_valid = 1'b0;
    endtask

    task automatic drive_operands(input logic [31:0] a, input logic [31:0] b, input int d2);
        int t1;
        int t2;
        t1 = (d2 < 0) ? -d2 : 0;
        t2 = (d2 > 0) ? d2 : 0;
        for (int t = 0; t <= t1 + t2; t++) begin
            in1.valid = (t == t1);
            in1.data  = a;
            in2.valid = (t == t2);
            in2.data  = b;
            @(posedge clk);
            #1;
        end
        in1.valid = 1'b0;
        in2.valid = 1'b0;
    endtask

    task automatic run_entry(input entry_t e);
        configure(e.op, e.width);
        drive_operands(e.a, e.b, e.d2);
        if (e.has_result) begin
            wait_results(1);
            check_value("data_out", results.pop_front(), e.exp_data);
        end
        wait_idle();
        check_value("data_valid_out extra pulses", 32'(results.size()), 32'h0);
    endtask

    task automatic run_load_burst();
        logic [31:0] exp_q [$];
        configure(grid_types_pkg::OP_LOAD, lsq_types_pkg::W_W);
        for (int i = 0; i < BURST_LEN; i++) begin
            exp_q.push_back(load_model(lsq_types_pkg::W_W, BURST_BASE + 32'(4 * i)));
        end
        // One address per cycle with noise on the ignored stream
        for (int i = 0; i < BURST_LEN; i++) begin
            in1.valid = 1'b1;
            in1.data  = BURST_BASE + 32'(4 * i);
            in2.valid = 1'b1;
            in2.data  = $urandom();
            @(posedge clk);
            #1;
            if (i == 0) begin
                loads_in_flight = BURST_LEN;   // First address now sits in the FIFO
            end
        end
        in1.valid = 1'b0;
        in2.valid = 1'b0;
        wait_results(BURST_LEN);
        foreach (exp_q[i]) begin
            check_value("data_out", results.pop_front(), exp_q[i]);
        end
        wait_idle();
        if (idle_early) begin
            stop_with_error("idle was high while burst loads were still in flight");
        end
        check_value("data_valid_out extra pulses", 32'(results.size()), 32'h0);
    endtask

    initial begin
        void'($urandom(58665));
        arst_n    = 1'b0;
        cfg_valid = 1'b0;
        cfg.op    = grid_types_pkg::OP_ADD;
        cfg.width = lsq_types_pkg::W_W;
        in1       = '0;
        in2       = '0;
        build_table();

        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_value("idle", 32'(idle), 32'h1);
        check_value("data_valid_out", 32'(data_valid_out), 32'h0);

        foreach (stim_table[i]) begin
            run_entry(stim_table[i]);
        end

        run_load_burst();

        // New function after the burst must show up in the next result
        add_entry(grid_types_pkg::OP_XOR, lsq_types_pkg::W_W, $urandom(), $urandom(), 2);
        run_entry(stim_table[stim_table.size() - 1]);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/lsq_types_pkg.sv
verilog/grid_types_pkg.sv
verilog/operand_fifo.sv
verilog/slot_op_unit.sv
verilog/grid_pr_slot.sv
verilog/slot_lsq.sv
verilog/grid_slot_top.sv
verif/tb_grid_slot.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_grid_slot
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
